// File: source/tart_pkg.sv
`default_nettype none

package tart_pkg;

   // ------------------------------------------------------------------
   // data and control types
   // ------------------------------------------------------------------
   typedef logic [23:0] sample_t;        // one bit per antenna

   typedef struct packed {
      logic       start;                 // acquisition enable
      logic       debug;                 // counter instead of antennas
      logic [2:0] sample_delay;          // strobe phase within a sample period
   } ctrl_t;

   // one host access, sampled in a single cycle
   typedef struct packed {
      logic       valid;
      logic       we;
      logic [3:0] adr;
      logic [7:0] dat;
   } host_req_t;

   typedef enum logic [1:0] {
      ST_IDLE    = 2'd0,
      ST_ACQUIRE = 2'd1,
      ST_FULL    = 2'd2,                 // reading back
      ST_DRAINED = 2'd3
   } store_state_e;

   // ------------------------------------------------------------------
   // host register map
   // ------------------------------------------------------------------
   localparam logic [3:0] REG_DATA0  = 4'h0;   // sample bits 7:0
   localparam logic [3:0] REG_DATA1  = 4'h1;   // sample bits 15:8
   localparam logic [3:0] REG_DATA2  = 4'h2;   // sample bits 23:16, pops the word
   localparam logic [3:0] REG_DELAY  = 4'h5;
   localparam logic [3:0] REG_DEBUG  = 4'h6;
   localparam logic [3:0] REG_START  = 4'h7;
   localparam logic [3:0] REG_STATUS = 4'he;

endpackage

`default_nettype wire

// File: source/antenna_capture.sv
`timescale 1ns/1ps
`default_nettype none

module antenna_capture #(
   parameter int RATIO = 6                  // fpga_clk cycles per sample, 2..8
) (
   input  wire                     fpga_clk,
   input  wire                     arst_n_i,
   input  wire tart_pkg::sample_t  antenna_i,
   input  wire tart_pkg::ctrl_t    ctrl_i,
   output logic                    cap_valid_o,
   output tart_pkg::sample_t       cap_data_o
);
   import tart_pkg::*;

   localparam logic [2:0] PH_LAST = 3'(RATIO - 1);

   sample_t    ant_q;                       // registered pins
   sample_t    dbg_cnt;                     // fake telescope
   sample_t    dbg_next;
   logic [2:0] phase;
   logic       strobe;
   logic       emit;
   logic       start_q;
   logic       start_rise;

   // ------------------------------------------------------------------
   // sample strobe, phase set by sample_delay
   // ------------------------------------------------------------------
   assign strobe     = (phase == ctrl_i.sample_delay);
   assign emit       = strobe & ctrl_i.start;
   assign start_rise = ctrl_i.start & ~start_q;

   // counter restarts at 0 on the start edge, even when a strobe
   // lands in that same cycle
   assign dbg_next = start_rise ? '0 : dbg_cnt;

   always_ff @(posedge fpga_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         phase       <= '0;
         start_q     <= 1'b0;
         cap_valid_o <= 1'b0;
         dbg_cnt     <= '0;
      end else begin
         phase       <= (phase == PH_LAST) ? 3'd0 : phase + 3'd1;   // free running
         start_q     <= ctrl_i.start;
         cap_valid_o <= emit;                                      // one cycle after strobe
         dbg_cnt     <= emit ? dbg_next + 24'd1 : dbg_next;        // one step per sample
      end
   end

   // ------------------------------------------------------------------
   // io register and source mux
   // ------------------------------------------------------------------
   always_ff @(posedge fpga_clk) begin
      ant_q <= antenna_i;
      if (emit) begin
         cap_data_o <= ctrl_i.debug ? dbg_next : ant_q;   // debug selects counter
      end
   end

endmodule

`default_nettype wire

// File: source/block_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module block_buffer #(
   parameter int CREDITS = 2                // initial credits toward the store
) (
   input  wire                     fpga_clk,
   input  wire                     arst_n_i,
   input  wire                     cap_valid_i,
   input  wire tart_pkg::sample_t  cap_data_i,
   output logic                    wr_valid_o,
   output tart_pkg::sample_t       wr_data_o,
   input  wire                     wr_credit_i
);
   import tart_pkg::*;

   localparam int CW = $clog2(CREDITS + 1);

   // four entries are plenty, since the store drains one word per cycle
   // and samples come at most once every RATIO cycles
   sample_t       ring [4];
   logic [2:0]    wp;                       // extra bit tells full from empty
   logic [2:0]    rp;
   logic [CW-1:0] credits;
   logic          empty;
   logic          send;

   assign empty = (wp == rp);
   assign send  = ~empty && (credits != '0);   // oldest entry goes out

   // ------------------------------------------------------------------
   // pointers and credit count
   // ------------------------------------------------------------------
   always_ff @(posedge fpga_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wp         <= '0;
         rp         <= '0;
         credits    <= CW'(CREDITS);
         wr_valid_o <= 1'b0;
      end else begin
         if (cap_valid_i) begin
            wp <= wp + 3'd1;
         end
         if (send) begin
            rp <= rp + 3'd1;
         end
         wr_valid_o <= send;
         // spend on send, refill on returned pulse
         credits <= credits - CW'(send) + CW'(wr_credit_i);
      end
   end

   // ------------------------------------------------------------------
   // ring storage
   // ------------------------------------------------------------------
   always_ff @(posedge fpga_clk) begin
      if (cap_valid_i) begin
         ring[wp[1:0]] <= cap_data_i;
      end
      if (send) begin
         wr_data_o <= ring[rp[1:0]];   // registered, one cycle after write
      end
   end

endmodule

`default_nettype wire

// File: source/sample_store.sv
`timescale 1ns/1ps
`default_nettype none

module sample_store #(
   parameter int DEPTH   = 16,              // words, power of two
   parameter int CREDITS = 2                // initial credits toward host prefetch
) (
   input  wire                       fpga_clk,
   input  wire                       arst_n_i,
   input  wire tart_pkg::ctrl_t      ctrl_i,
   input  wire                       wr_valid_i,
   input  wire tart_pkg::sample_t    wr_data_i,
   output logic                      wr_credit_o,
   output logic                      rd_valid_o,
   output tart_pkg::sample_t         rd_data_o,
   input  wire                       rd_credit_i,
   output tart_pkg::store_state_e    state_o
);
   import tart_pkg::*;

   localparam int            AW   = $clog2(DEPTH);
   localparam int            CW   = $clog2(CREDITS + 1);
   localparam logic [AW-1:0] LAST = AW'(DEPTH - 1);

   sample_t       mem [DEPTH];              // stands in for the sdram
   store_state_e  state;
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] credits;
   logic          start_q;
   logic          start_rise;
   logic          do_write;
   logic          do_send;

   assign start_rise = ctrl_i.start & ~start_q;
   assign do_write   = wr_valid_i && (state == ST_ACQUIRE);   // others dropped
   assign do_send    = (state == ST_FULL) && (credits != '0);
   assign state_o    = state;

   // ------------------------------------------------------------------
   // acquisition scheduler
   // ------------------------------------------------------------------
   always_ff @(posedge fpga_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state       <= ST_IDLE;
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         credits     <= CW'(CREDITS);
         start_q     <= 1'b0;
         wr_credit_o <= 1'b0;
         rd_valid_o  <= 1'b0;
      end else begin
         start_q     <= ctrl_i.start;
         wr_credit_o <= wr_valid_i;         // credit back even for discarded words
         rd_valid_o  <= do_send;
         credits     <= credits - CW'(do_send) + CW'(rd_credit_i);
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_send) begin
            rd_ptr <= rd_ptr + 1'b1;
         end

         if (start_rise) begin
            // new run from any state, old contents are overwritten
            state  <= ST_ACQUIRE;
            wr_ptr <= '0;
         end else begin
            case (state)
               ST_ACQUIRE: begin
                  if (do_write && (wr_ptr == LAST)) begin
                     state  <= ST_FULL;     // DEPTH-th write
                     rd_ptr <= '0;
                  end
               end
               ST_FULL: begin
                  if (do_send && (rd_ptr == LAST)) begin
                     state <= ST_DRAINED;   // last word handed out
                  end
               end
               default: ;                   // idle and drained wait for start
            endcase
         end
      end
   end

   // ------------------------------------------------------------------
   // sample memory, read back in address order
   // ------------------------------------------------------------------
   always_ff @(posedge fpga_clk) begin
      if (do_write) begin
         mem[wr_ptr] <= wr_data_i;
      end
      if (do_send) begin
         rd_data_o <= mem[rd_ptr];
      end
   end

endmodule

`default_nettype wire

// File: source/host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module host_regs #(
   parameter int CREDITS = 2                // prefetch depth, matches store credits
) (
   input  wire                          fpga_clk,
   input  wire                          arst_n_i,
   input  wire tart_pkg::host_req_t     host_req_i,
   output logic [7:0]                   host_rdata_o,
   output tart_pkg::ctrl_t              ctrl_o,
   input  wire                          rd_valid_i,
   input  wire tart_pkg::sample_t       rd_data_i,
   output logic                         rd_credit_o,
   input  wire tart_pkg::store_state_e  state_i
);
   import tart_pkg::*;

   localparam int            CW    = $clog2(CREDITS + 1);
   localparam int            PW    = (CREDITS > 1) ? $clog2(CREDITS) : 1;
   localparam logic [PW-1:0] PLAST = PW'(CREDITS - 1);

   ctrl_t         ctrl_q;
   sample_t       fifo [CREDITS];           // prefetched words
   sample_t       head;
   logic [PW-1:0] head_ptr;
   logic [PW-1:0] tail_ptr;
   logic [CW-1:0] count;
   logic          avail;
   logic          rd_req;
   logic          wr_req;
   logic          pop;
   logic [7:0]    status;
   logic [7:0]    rdata;

   assign rd_req = host_req_i.valid & ~host_req_i.we;
   assign wr_req = host_req_i.valid & host_req_i.we;
   assign avail  = (count != '0);
   assign head   = avail ? fifo[head_ptr] : '0;   // empty fifo reads as zero
   assign pop    = rd_req && (host_req_i.adr == REG_DATA2) && avail;
   assign status = {3'b000, ctrl_q.debug, ctrl_q.start, avail, state_i};
   assign ctrl_o = ctrl_q;

   // ------------------------------------------------------------------
   // read mux
   // ------------------------------------------------------------------
   always_comb begin
      case (host_req_i.adr)
         REG_DATA0:  rdata = head[7:0];
         REG_DATA1:  rdata = head[15:8];
         REG_DATA2:  rdata = head[23:16];
         REG_DELAY:  rdata = {5'b00000, ctrl_q.sample_delay};
         REG_DEBUG:  rdata = {7'b0000000, ctrl_q.debug};
         REG_START:  rdata = {7'b0000000, ctrl_q.start};
         REG_STATUS: rdata = status;
         default:    rdata = 8'h00;         // unmapped
      endcase
   end

   // ------------------------------------------------------------------
   // control registers, prefetch pointers, read data
   // ------------------------------------------------------------------
   always_ff @(posedge fpga_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_q       <= '0;
         head_ptr     <= '0;
         tail_ptr     <= '0;
         count        <= '0;
         rd_credit_o  <= 1'b0;
         host_rdata_o <= 8'h00;
      end else begin
         if (wr_req) begin
            case (host_req_i.adr)
               REG_DELAY: ctrl_q.sample_delay <= host_req_i.dat[2:0];
               REG_DEBUG: ctrl_q.debug        <= host_req_i.dat[0];
               REG_START: ctrl_q.start        <= host_req_i.dat[0];
               default: ;
            endcase
         end
         if (rd_req) begin
            host_rdata_o <= rdata;          // valid the cycle after the request
         end
         rd_credit_o <= pop;                // one credit per popped word
         if (rd_valid_i) begin
            tail_ptr <= (tail_ptr == PLAST) ? '0 : tail_ptr + 1'b1;
         end
         if (pop) begin
            head_ptr <= (head_ptr == PLAST) ? '0 : head_ptr + 1'b1;
         end
         count <= count + CW'(rd_valid_i) - CW'(pop);
      end
   end

   // store only sends with a credit, so no overflow here
   always_ff @(posedge fpga_clk) begin
      if (rd_valid_i) begin
         fifo[tail_ptr] <= rd_data_i;
      end
   end

endmodule

`default_nettype wire

// File: source/tart_top.sv
`timescale 1ns/1ps
`default_nettype none

module tart_top #(
   parameter int DEPTH   = 16,              // store words
   parameter int RATIO   = 6,               // fpga_clk cycles per sample
   parameter int CREDITS = 2                // credits per link
) (
   input  wire                       fpga_clk,
   input  wire                       arst_n_i,
   input  wire tart_pkg::sample_t    antenna_i,
   input  wire tart_pkg::host_req_t  host_req_i,
   output logic [7:0]                host_rdata_o,
   output logic                      led_o
);
   import tart_pkg::*;

   ctrl_t        ctrl;
   logic         cap_valid;
   sample_t      cap_data;
   logic         wr_valid;
   sample_t      wr_data;
   logic         wr_credit;
   logic         rd_valid;
   sample_t      rd_data;
   logic         rd_credit;
   store_state_e state;

   assign led_o = (state >= ST_FULL);       // data can be read back

   // ------------------------------------------------------------------
   // capture, buffer, store, host port
   // ------------------------------------------------------------------
   antenna_capture #(.RATIO(RATIO)) capture0 (
      .fpga_clk, .arst_n_i, .antenna_i, .ctrl_i(ctrl),
      .cap_valid_o(cap_valid), .cap_data_o(cap_data)
   );

   block_buffer #(.CREDITS(CREDITS)) buffer0 (
      .fpga_clk, .arst_n_i, .cap_valid_i(cap_valid), .cap_data_i(cap_data),
      .wr_valid_o(wr_valid), .wr_data_o(wr_data), .wr_credit_i(wr_credit)
   );

   sample_store #(.DEPTH(DEPTH), .CREDITS(CREDITS)) store0 (
      .fpga_clk, .arst_n_i, .ctrl_i(ctrl),
      .wr_valid_i(wr_valid), .wr_data_i(wr_data), .wr_credit_o(wr_credit),
      .rd_valid_o(rd_valid), .rd_data_o(rd_data), .rd_credit_i(rd_credit),
      .state_o(state)
   );

   host_regs #(.CREDITS(CREDITS)) regs0 (
      .fpga_clk, .arst_n_i, .host_req_i, .host_rdata_o, .ctrl_o(ctrl),
      .rd_valid_i(rd_valid), .rd_data_i(rd_data), .rd_credit_o(rd_credit),
      .state_i(state)
   );

endmodule

`default_nettype wire

// File: test/tart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tart_tb;
   import tart_pkg::*;

   localparam int DEPTH    = 16;
   localparam int RATIO    = 6;
   localparam int CREDITS  = 2;
   localparam int N_ROWS   = 4;
   localparam int POLL_MAX = DEPTH * RATIO * 2;             // status polls before giving up
   localparam int WATCH    = N_ROWS * DEPTH * RATIO * 40;   // watchdog, in cycles

   typedef struct packed {
      logic       debug;
      logic [2:0] delay;
      sample_t    value;                    // zero draws from the lfsr
      logic [7:0] pause;                    // idle cycles between word reads
   } row_t;

   // long pauses starve the store of credits
   row_t rows [N_ROWS] = '{
      '{1'b1, 3'd0, 24'h000000, 8'd0},
      '{1'b0, 3'd3, 24'h5a3c96, 8'd0},
      '{1'b1, 3'd5, 24'h000000, 8'd25},
      '{1'b0, 3'd1, 24'h000000, 8'd10}
   };

   logic       fpga_clk;
   logic       arst_n_i;
   sample_t    antenna_i;
   host_req_t  host_req;
   logic [7:0] host_rdata;
   logic       led_o;
   logic [31:0] lfsr;
   int         value_errors;
   int         other_errors;

   tart_top #(.DEPTH(DEPTH), .RATIO(RATIO), .CREDITS(CREDITS)) UUT (
      .fpga_clk, .arst_n_i, .antenna_i, .host_req_i(host_req),
      .host_rdata_o(host_rdata), .led_o
   );

   always #4 fpga_clk = ~fpga_clk;          // 8 ns period

   // ------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------
   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_sample(output sample_t v);
      v = '0;
      for (int i = 0; i < 24; i++) begin
         lfsr = lfsr_next(lfsr);            // one step per bit
         v    = {v[22:0], lfsr[0]};
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge fpga_clk);
   endtask

   // one request cycle, data sampled one cycle later
   task automatic host_access(input logic we, input logic [3:0] adr,
                              input logic [7:0] dat, output logic [7:0] rd);
      @(posedge fpga_clk);
      #1;
      host_req = {1'b1, we, adr, dat};
      @(posedge fpga_clk);
      #1;
      host_req = '0;
      rd       = host_rdata;                // registered, stable here
   endtask

   task automatic host_write(input logic [3:0] adr, input logic [7:0] dat);
      logic [7:0] unused;
      host_access(1'b1, adr, dat, unused);
   endtask

   task automatic host_read(input logic [3:0] adr, output logic [7:0] rd);
      host_access(1'b0, adr, 8'h00, rd);
   endtask

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      if (got !== exp) begin
         value_errors++;
         $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_state(input string name, input store_state_e got,
                              input store_state_e exp);
      if (got !== exp) begin
         value_errors++;
         $display("ERROR t=%0t %s: got %0d expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         value_errors++;
         $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   // poll status until the masked bits match, bounded
   task automatic wait_status(input logic [7:0] mask, input logic [7:0] want,
                              input string what);
      logic [7:0] st;
      int         polls;
      polls = 0;
      do begin
         host_read(REG_STATUS, st);
         polls++;
      end while (((st & mask) != want) && (polls < POLL_MAX));
      if ((st & mask) != want) begin
         other_errors++;
         $display("t=%0t: waited %0d status reads, still no %s", $time, polls, what);
      end
   endtask

   // ------------------------------------------------------------------
   // watchdog
   // ------------------------------------------------------------------
   initial begin
      repeat (WATCH) @(posedge fpga_clk);
      $display("t=%0t: watchdog expired, the run did not finish in time", $time);
      $display("Done: errors found");
      $finish;
   end

   // ------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------
   initial begin
      row_t       cur;
      sample_t    value;
      sample_t    word;
      sample_t    exp_word;
      logic [7:0] rd;
      logic [7:0] b0;
      logic [7:0] b1;
      logic [7:0] b2;
      fpga_clk     = 1'b0;
      arst_n_i     = 1'b0;
      antenna_i    = '0;
      host_req     = '0;
      lfsr         = 32'h10df;
      value_errors = 0;
      other_errors = 0;
      repeat (10) @(posedge fpga_clk);
      #1;
      arst_n_i = 1'b1;

      // reset values, then plain register read-back
      host_read(REG_STATUS, rd);
      check_state("status state", store_state_e'(rd[1:0]), ST_IDLE);
      check_byte("REG_STATUS", rd, 8'h00);
      check_byte("led_o", {7'b0, led_o}, 8'h00);
      host_read(REG_DELAY, rd);
      check_byte("REG_DELAY", rd, 8'h00);
      host_read(REG_DEBUG, rd);
      check_byte("REG_DEBUG", rd, 8'h00);
      host_read(REG_START, rd);
      check_byte("REG_START", rd, 8'h00);
      host_write(REG_DELAY, 8'h05);
      host_write(REG_DEBUG, 8'h01);
      host_read(REG_DELAY, rd);
      check_byte("REG_DELAY", rd, 8'h05);
      host_read(REG_DEBUG, rd);
      check_byte("REG_DEBUG", rd, 8'h01);

      for (int r = 0; r < N_ROWS; r++) begin
         cur   = rows[r];
         value = cur.value;
         if (value == '0) begin
            draw_sample(value);
         end
         @(posedge fpga_clk);
         #1;
         antenna_i = value;                 // held for the whole acquisition
         host_write(REG_DELAY, {5'b00000, cur.delay});
         host_write(REG_DEBUG, {7'b0000000, cur.debug});
         host_write(REG_START, 8'h00);
         idle(2 * RATIO);                   // buffer empties before the restart
         host_write(REG_START, 8'h01);

         host_read(REG_START, rd);
         check_byte("REG_START", rd, 8'h01);
         host_read(REG_STATUS, rd);
         check_state("status state", store_state_e'(rd[1:0]), ST_ACQUIRE);
         check_byte("REG_STATUS", rd, {3'b000, cur.debug, 1'b1, 1'b0, 2'b01});
         check_byte("led_o", {7'b0, led_o}, 8'h00);

         wait_status(8'h03, 8'h02, "full store");
         check_byte("led_o", {7'b0, led_o}, 8'h01);

         // read back in address order
         for (int k = 0; k < DEPTH; k++) begin
            idle(cur.pause);
            wait_status(8'h04, 8'h04, "word available");
            host_read(REG_DATA0, b0);
            host_read(REG_DATA1, b1);
            host_read(REG_DATA2, b2);  // pops
            word     = {b2, b1, b0};
            exp_word = cur.debug ? sample_t'(k) : value;
            check_sample($sformatf("row %0d word %0d", r, k), word, exp_word);
         end

         host_read(REG_STATUS, rd);
         check_state("status state", store_state_e'(rd[1:0]), ST_DRAINED);
         check_byte("REG_STATUS", rd, {3'b000, cur.debug, 1'b1, 1'b0, 2'b11});
         host_read(REG_DATA0, rd);          // empty prefetch reads zero
         check_byte("REG_DATA0", rd, 8'h00);
      end

      $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
      if ((value_errors + other_errors) == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
source/tart_pkg.sv
source/antenna_capture.sv
source/block_buffer.sv
source/sample_store.sv
source/host_regs.sv
source/tart_top.sv
test/tart_tb.sv

// File: Bender.yml
package:
  name: tart_acq

sources:
  - source/tart_pkg.sv
  - source/antenna_capture.sv
  - source/block_buffer.sv
  - source/sample_store.sv
  - source/host_regs.sv
  - source/tart_top.sv
  - target: test
    files:
      - test/tart_tb.sv
